// ==== design/mipsPkg.sv ====
package mipsPkg;

    //////////////////////////////
    // Instruction word, two views
    //////////////////////////////
    typedef union packed
    {
        struct packed
        {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;                                // Register format
        struct packed
        {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iType;                                // Immediate format
    } instrWord_u;

    // ALU operation class from main control
    localparam logic [1:0] ALUOP_MEM    = 2'b00;    // lw / sw, add
    localparam logic [1:0] ALUOP_BRANCH = 2'b01;    // beq, subtract
    localparam logic [1:0] ALUOP_RTYPE  = 2'b10;    // Decode funct
    localparam logic [1:0] ALUOP_IMM    = 2'b11;    // Decode opcode

    // ALU codes
    localparam logic [3:0] ALU_AND = 4'b0000;
    localparam logic [3:0] ALU_OR  = 4'b0001;
    localparam logic [3:0] ALU_ADD = 4'b0010;
    localparam logic [3:0] ALU_SRL = 4'b0011;
    localparam logic [3:0] ALU_SRA = 4'b0100;
    localparam logic [3:0] ALU_NOR = 4'b0101;
    localparam logic [3:0] ALU_SUB = 4'b0110;
    localparam logic [3:0] ALU_SLT = 4'b0111;
    localparam logic [3:0] ALU_XOR = 4'b1001;
    localparam logic [3:0] ALU_SLL = 4'b1011;

    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_ANDI  = 6'b001100;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_XORI  = 6'b001110;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;

    // R-type function codes
    localparam logic [5:0] F_ADD  = 6'b100000;
    localparam logic [5:0] F_SUB  = 6'b100010;
    localparam logic [5:0] F_AND  = 6'b100100;
    localparam logic [5:0] F_OR   = 6'b100101;
    localparam logic [5:0] F_XOR  = 6'b100110;
    localparam logic [5:0] F_NOR  = 6'b100111;
    localparam logic [5:0] F_SLT  = 6'b101010;
    localparam logic [5:0] F_SLL  = 6'b000000;
    localparam logic [5:0] F_SRL  = 6'b000010;
    localparam logic [5:0] F_SRA  = 6'b000011;
    localparam logic [5:0] F_SLLV = 6'b000100;
    localparam logic [5:0] F_SRLV = 6'b000110;
    localparam logic [5:0] F_SRAV = 6'b000111;

endpackage

// ==== design/ctrlIf.sv ====
`timescale 1ns/1ns

interface ctrlIf;

    logic [1:0] aluOp;          // Operation class
    logic       regDst;         // Dest is rd, else rt
    logic       aluSrcImm;      // Operand B from immediate
    logic       immZeroExt;     // Zero-extend imm (logic ops)
    logic       regWrite;       // Write back result
    logic       isBranch;       // beq, report zero flag

    // Driver side, main control
    modport ctrl
    (
        output aluOp, regDst, aluSrcImm, immZeroExt, regWrite, isBranch
    );

    // ALU control only needs the class
    modport alu (input aluOp);

    // Datapath selects
    modport dp
    (
        input regDst, aluSrcImm, immZeroExt, regWrite, isBranch
    );

endinterface

// ==== design/mainControl.sv ====
`timescale 1ns/1ns

module mainControl import mipsPkg::*;
(
    input instrWord_u instr,
    ctrlIf.ctrl       ctrl
);

    logic functKnown;   // R-type funct is one we execute

    always_comb
    begin
        functKnown = instr.rType.funct inside {F_ADD, F_SUB, F_AND, F_OR, F_XOR, F_NOR,
                                               F_SLT, F_SLL, F_SRL, F_SRA, F_SLLV,
                                               F_SRLV, F_SRAV};
    end

    always_comb
    begin
        // Defaults: add on registers, no write
        ctrl.aluOp      = ALUOP_MEM;
        ctrl.regDst     = 1'b0;
        ctrl.aluSrcImm  = 1'b0;
        ctrl.immZeroExt = 1'b0;
        ctrl.regWrite   = 1'b0;
        ctrl.isBranch   = 1'b0;
        case (instr.rType.opcode)
            OP_RTYPE:
            begin
                ctrl.aluOp    = ALUOP_RTYPE;
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = functKnown;     // Unknown funct, add without write
            end
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI:
            begin
                ctrl.aluOp      = ALUOP_IMM;
                ctrl.aluSrcImm  = 1'b1;
                ctrl.regWrite   = 1'b1;         // Writes rt
                // Logic immediates zero-extend
                ctrl.immZeroExt = (instr.iType.opcode != OP_ADDI);
            end
            OP_BEQ:
            begin
                ctrl.aluOp    = ALUOP_BRANCH;   // rs - rt
                ctrl.isBranch = 1'b1;
            end
            OP_LW, OP_SW:
                ctrl.aluSrcImm = 1'b1;          // Address = rs + simm
            default:
                ctrl.aluOp = ALUOP_MEM;         // Unknown, plain add
        endcase
    end

endmodule

// ==== design/aluControl.sv ====
`timescale 1ns/1ns

module aluControl import mipsPkg::*;
(
    ctrlIf.alu         ctrl,
    input  logic [5:0] funct,       // funct field, or opcode for imm class
    output logic [3:0] aluCode,
    output logic       shiftVar     // Shift amount from rs
);

    //////////////////////////////
    // ALU code decode
    //////////////////////////////
    always_comb
    begin
        aluCode = ALU_ADD;
        case (ctrl.aluOp)
            ALUOP_MEM:    aluCode = ALU_ADD;    // Address add
            ALUOP_BRANCH: aluCode = ALU_SUB;    // Compare by subtract
            ALUOP_RTYPE:
            begin
                case (funct)
                    F_ADD:          aluCode = ALU_ADD;
                    F_SUB:          aluCode = ALU_SUB;
                    F_AND:          aluCode = ALU_AND;
                    F_OR:           aluCode = ALU_OR;
                    F_XOR:          aluCode = ALU_XOR;
                    F_NOR:          aluCode = ALU_NOR;
                    F_SLT:          aluCode = ALU_SLT;
                    F_SRA, F_SRAV:  aluCode = ALU_SRA;  // Fixed and variable share code
                    F_SRL, F_SRLV:  aluCode = ALU_SRL;
                    F_SLL, F_SLLV:  aluCode = ALU_SLL;
                    default:        aluCode = ALU_ADD;
                endcase
            end
            ALUOP_IMM:
            begin
                // Opcode arrives on the funct lines here
                case (funct)
                    OP_ADDI: aluCode = ALU_ADD;
                    OP_ANDI: aluCode = ALU_AND;
                    OP_ORI:  aluCode = ALU_OR;
                    OP_XORI: aluCode = ALU_XOR;
                    default: aluCode = ALU_ADD;
                endcase
            end
            default: aluCode = ALU_ADD;
        endcase
    end

    // Variable shifts, R-type only
    always_comb
    begin
        shiftVar = 1'b0;
        if (ctrl.aluOp == ALUOP_RTYPE)
        begin
            shiftVar = funct inside {F_SLLV, F_SRLV, F_SRAV};
        end
    end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ns

module regFile
(
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    input  logic [4:0]  wrAddr,
    input  logic        wrEn,
    input  logic [31:0] wrData,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB
);

    logic [31:0] regs [32];

    //////////////////////////////
    // Write port
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;  // Whole file cleared
            end
        end
        else if (wrEn && (wrAddr != 5'd0))
        begin
            regs[wrAddr] <= wrData;     // r0 never written
        end
    end

    //////////////////////////////
    // Read ports, combinational
    //////////////////////////////
    always_comb
    begin
        rdDataA = regs[rdAddrA];
        if (rdAddrA == 5'd0)
        begin
            rdDataA = '0;               // r0 hardwired
        end
    end

    always_comb
    begin
        rdDataB = regs[rdAddrB];
        if (rdAddrB == 5'd0)
        begin
            rdDataB = '0;
        end
    end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ns

module alu import mipsPkg::*;
(
    input  logic [3:0]  aluCode,
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    input  logic [4:0]  shamt,      // Already muxed, shamt or rs[4:0]
    output logic [31:0] result,
    output logic        zero
);

    logic        isLess;     // Signed compare for slt
    logic [31:0] sraOut;

    always_comb
    begin
        isLess = $signed(opA) < $signed(opB);
    end

    // Arithmetic shift keeps the sign of opB
    always_comb
    begin
        sraOut = $unsigned($signed(opB) >>> shamt);
    end

    //////////////////////////////
    // Result select
    //////////////////////////////
    always_comb
    begin
        case (aluCode)
            ALU_AND: result = opA & opB;
            ALU_OR:  result = opA | opB;
            ALU_ADD: result = opA + opB;
            ALU_SUB: result = opA - opB;        // Also beq compare
            ALU_XOR: result = opA ^ opB;
            ALU_NOR: result = ~(opA | opB);
            ALU_SLT: result = {31'd0, isLess};
            ALU_SLL: result = opB << shamt;     // Shifts work on opB (rt)
            ALU_SRL: result = opB >> shamt;
            ALU_SRA: result = sraOut;
            default: result = opA + opB;        // Unused codes fall to add
        endcase
    end

    // Zero flag over the full word
    always_comb
    begin
        zero = (result == 32'd0);
    end

endmodule

// ==== design/execUnit.sv ====
`timescale 1ns/1ns

module execUnit import mipsPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        instrValid,
    input  logic [31:0] instr,
    output logic        resValid,
    output logic [31:0] resData,
    output logic [4:0]  resReg,
    output logic        resWrite,
    output logic        resZero
);

    instrWord_u  instrW;                    // Same word, both views
    logic [5:0]  aluFunct;
    logic [3:0]  aluCode;
    logic        shiftVar;
    logic [31:0] rdDataA, rdDataB, immExt, opB, aluResult;
    logic [4:0]  shiftAmt, destReg;
    logic        aluZero, wrEn;

    ctrlIf ctrlBus ();

    assign instrW = instr;

    mainControl uMainControl (.instr(instrW), .ctrl(ctrlBus.ctrl));

    aluControl uAluControl (.ctrl(ctrlBus.alu), .funct(aluFunct), .aluCode(aluCode),
                            .shiftVar(shiftVar));

    regFile uRegFile (.clk(clk), .rstN(rstN), .rdAddrA(instrW.rType.rs),
                      .rdAddrB(instrW.rType.rt), .wrAddr(destReg), .wrEn(wrEn),
                      .wrData(aluResult), .rdDataA(rdDataA), .rdDataB(rdDataB));

    alu uAlu (.aluCode(aluCode), .opA(rdDataA), .opB(opB), .shamt(shiftAmt),
              .result(aluResult), .zero(aluZero));

    //////////////////////////////
    // Operand and dest selects
    //////////////////////////////
    // Immediate class decodes the opcode on the funct lines
    assign aluFunct = ctrlBus.aluSrcImm ? instrW.iType.opcode : instrW.rType.funct;
    assign immExt   = ctrlBus.immZeroExt ? {16'd0, instrW.iType.imm}
                                         : {{16{instrW.iType.imm[15]}}, instrW.iType.imm};
    assign opB      = ctrlBus.aluSrcImm ? immExt : rdDataB;
    assign shiftAmt = shiftVar ? rdDataA[4:0] : instrW.rType.shamt;   // sllv/srlv/srav
    assign destReg  = ctrlBus.regDst ? instrW.rType.rd : instrW.rType.rt;
    assign wrEn     = instrValid & ctrlBus.regWrite;    // Shared with write-back flag

    // Result flags, one-cycle strobe
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            resValid <= 1'b0;
            resWrite <= 1'b0;
            resZero  <= 1'b0;
        end
        else
        begin
            resValid <= instrValid;
            resWrite <= wrEn;
            resZero  <= instrValid & ctrlBus.isBranch & aluZero;  // beq only
        end
    end

    // Payload, held between instructions
    always_ff @(posedge clk)
    begin
        if (instrValid)
        begin
            resData <= aluResult;
            resReg  <= destReg;
        end
    end

endmodule

// ==== dv/tbClock.sv ====
`timescale 1ns/1ns

module tbClock
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;   // 8 ns period

endmodule

// ==== dv/execChecker.sv ====
`timescale 1ns/1ns

module execChecker
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        instrValid,
    input  logic [31:0] rowIdx,     // Table row now on the DUT inputs
    input  logic [31:0] expData,
    input  logic [4:0]  expReg,
    input  logic        expWrite,
    input  logic        expZero,
    input  logic        resValid,
    input  logic [31:0] resData,
    input  logic [4:0]  resReg,
    input  logic        resWrite,
    input  logic        resZero,
    output logic [31:0] errCount,
    output logic [31:0] checkCount  // Results consumed, good or bad
);

    // Instruction taken last edge, result due now
    logic        pendValid;
    logic [31:0] pendIdx, pendData;
    logic [4:0]  pendReg;
    logic        pendWrite, pendZero;

    initial
    begin
        errCount   = 0;
        checkCount = 0;
        pendValid  = 1'b0;
    end

    task automatic compareField(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED @ %0t ns: row %0d %s got %h expected %h",
                     $time, pendIdx, what, got, exp);
            errCount = errCount + 1;
        end
    endtask

    //////////////////////////////
    // Result compare
    //////////////////////////////
    always @(posedge clk)
    begin
        if (!rstN)
        begin
            pendValid <= 1'b0;
        end
        else
        begin
            if (resValid === 1'b1)
            begin
                if (!pendValid)
                begin
                    $display("Error at %0t ns: resValid pulsed with no instruction pending", $time);
                    errCount = errCount + 1;
                end
                else
                begin
                    compareField("resData", resData, pendData);
                    compareField("resReg", {27'd0, resReg}, {27'd0, pendReg});
                    compareField("resWrite", {31'd0, resWrite}, {31'd0, pendWrite});
                    compareField("resZero", {31'd0, resZero}, {31'd0, pendZero});
                    checkCount = checkCount + 1;
                end
            end
            else if (pendValid)
            begin
                $display("Error at %0t ns: row %0d gave no result one cycle after it was taken",
                         $time, pendIdx);
                errCount   = errCount + 1;
                checkCount = checkCount + 1;
            end
            // Capture what the DUT takes on this edge
            pendValid <= instrValid;
            pendIdx   <= rowIdx;
            pendData  <= expData;
            pendReg   <= expReg;
            pendWrite <= expWrite;
            pendZero  <= expZero;
        end
    end

endmodule

// ==== dv/tbExecUnit.sv ====
`timescale 1ns/1ns

module tbExecUnit import mipsPkg::*;
();

    localparam int MAX_ROWS = 64;

    logic        clk, rstN, instrValid;
    logic [31:0] instr;
    logic        resValid, resWrite, resZero;
    logic [31:0] resData;
    logic [4:0]  resReg;
    logic [31:0] rowIdx, expData;   // Expected values ride along with the instruction
    logic [4:0]  expReg;
    logic        expWrite, expZero;
    logic [31:0] errCount, checkCount;

    //////////////////////////////
    // Stimulus table
    //////////////////////////////
    logic [31:0] tabInstr [MAX_ROWS];
    logic        tabValid [MAX_ROWS];   // Low for idle cycles
    logic [31:0] tabData  [MAX_ROWS];
    logic [4:0]  tabReg   [MAX_ROWS];
    logic        tabWrite [MAX_ROWS];
    logic        tabZero  [MAX_ROWS];
    int          rowCount, validRows;
    logic [31:0] shadow [32];           // Reference register state
    logic [31:0] rnd;
    logic        tableReady;

    tbClock uClock (.clk(clk));

    execUnit uut (.clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
                  .resValid(resValid), .resData(resData), .resReg(resReg),
                  .resWrite(resWrite), .resZero(resZero));

    execChecker uChecker (.clk(clk), .rstN(rstN), .instrValid(instrValid), .rowIdx(rowIdx),
                          .expData(expData), .expReg(expReg), .expWrite(expWrite),
                          .expZero(expZero), .resValid(resValid), .resData(resData),
                          .resReg(resReg), .resWrite(resWrite), .resZero(resZero),
                          .errCount(errCount), .checkCount(checkCount));

    function automatic logic [31:0] encodeR(input logic [5:0] funct, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd,
                                            input logic [4:0] shamt);
        instrWord_u w;
        w.rType.opcode = OP_RTYPE;
        w.rType.rs     = rs;
        w.rType.rt     = rt;
        w.rType.rd     = rd;
        w.rType.shamt  = shamt;
        w.rType.funct  = funct;
        return w;
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        instrWord_u w;
        w.iType.opcode = op;
        w.iType.rs     = rs;
        w.iType.rt     = rt;
        w.iType.imm    = imm;
        return w;
    endfunction

    task automatic addIdle();
        tabInstr[rowCount] = encodeI(OP_ADDI, 5'd0, 5'd1, 16'hBEEF);  // Would clobber r1 if taken
        tabValid[rowCount] = 1'b0;
        tabData[rowCount]  = '0;
        tabReg[rowCount]   = '0;
        tabWrite[rowCount] = 1'b0;
        tabZero[rowCount]  = 1'b0;
        rowCount++;
    endtask

    // Runs one instruction on the shadow registers and appends its row
    task automatic addInstr(input logic [31:0] word);
        instrWord_u  w;
        logic [31:0] a, b, r, simm, zimm;
        logic [4:0]  sh, dst;
        logic        wr, z;
        w    = word;
        a    = shadow[w.rType.rs];
        b    = shadow[w.rType.rt];
        simm = {{16{w.iType.imm[15]}}, w.iType.imm};
        zimm = {16'd0, w.iType.imm};
        sh   = w.rType.shamt;
        r    = a + b;               // Unknown codes add
        dst  = w.iType.rt;
        wr   = 1'b0;
        z    = 1'b0;
        case (w.rType.opcode)
            OP_RTYPE:
            begin
                dst = w.rType.rd;
                wr  = 1'b1;
                if (w.rType.funct == F_SLLV || w.rType.funct == F_SRLV || w.rType.funct == F_SRAV)
                begin
                    sh = a[4:0];    // Variable amount from rs
                end
                case (w.rType.funct)
                    F_ADD:         r = a + b;
                    F_SUB:         r = a - b;
                    F_AND:         r = a & b;
                    F_OR:          r = a | b;
                    F_XOR:         r = a ^ b;
                    F_NOR:         r = ~(a | b);
                    F_SLT:         r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
                    F_SLL, F_SLLV: r = b << sh;
                    F_SRL, F_SRLV: r = b >> sh;
                    F_SRA, F_SRAV: r = (b >> sh) | (b[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
                    default:       wr = 1'b0;
                endcase
            end
            OP_ADDI, OP_ANDI, OP_ORI, OP_XORI:
            begin
                wr = 1'b1;
                case (w.iType.opcode)
                    OP_ADDI: r = a + simm;
                    OP_ANDI: r = a & zimm;
                    OP_ORI:  r = a | zimm;
                    default: r = a ^ zimm;
                endcase
            end
            OP_BEQ:
            begin
                r = a - b;
                z = (a == b);
            end
            OP_LW, OP_SW: r = a + simm;     // Address only
            default:      r = a + b;
        endcase
        if (wr && dst != 5'd0)
        begin
            shadow[dst] = r;
        end
        tabInstr[rowCount] = word;
        tabValid[rowCount] = 1'b1;
        tabData[rowCount]  = r;
        tabReg[rowCount]   = dst;
        tabWrite[rowCount] = wr;
        tabZero[rowCount]  = z;
        rowCount++;
        validRows++;
    endtask

    task automatic buildTable();
        logic [5:0] pick;
        int         k;
        rowCount  = 0;
        validRows = 0;
        for (k = 0; k < 32; k++)
        begin
            shadow[k] = '0;
        end
        // Loads and r0
        addInstr(encodeI(OP_ADDI, 5'd0, 5'd1, 16'h1234));
        addInstr(encodeI(OP_ADDI, 5'd0, 5'd2, 16'hFFFB));      // -5
        rnd = $urandom();
        addInstr(encodeI(OP_ADDI, 5'd0, 5'd3, rnd[15:0]));
        rnd = $urandom();
        addInstr(encodeI(OP_ADDI, 5'd0, 5'd4, rnd[15:0]));
        addInstr(encodeI(OP_ADDI, 5'd1, 5'd0, 16'h0007));      // Write aimed at r0
        addInstr(encodeR(F_ADD, 5'd0, 5'd1, 5'd5, 5'd0));      // r0 must still read zero
        // Logic immediates
        addInstr(encodeI(OP_ANDI, 5'd2, 5'd6, 16'h8F0F));
        addInstr(encodeI(OP_ORI, 5'd0, 5'd7, 16'h8000));
        rnd = $urandom();
        addInstr(encodeI(OP_XORI, 5'd2, 5'd8, rnd[15:0]));
        rnd = $urandom();
        addInstr(encodeI(OP_ORI, 5'd3, 5'd9, rnd[15:0]));
        addIdle();
        // R-type back to back
        addInstr(encodeR(F_ADD, 5'd1, 5'd2, 5'd10, 5'd0));
        addInstr(encodeR(F_SUB, 5'd1, 5'd2, 5'd11, 5'd0));
        addInstr(encodeR(F_XOR, 5'd10, 5'd11, 5'd12, 5'd0));  // Both previous results
        addInstr(encodeR(F_AND, 5'd3, 5'd4, 5'd13, 5'd0));
        addInstr(encodeR(F_OR, 5'd3, 5'd4, 5'd14, 5'd0));
        addInstr(encodeR(F_NOR, 5'd1, 5'd2, 5'd15, 5'd0));
        addInstr(encodeR(F_SLT, 5'd2, 5'd1, 5'd16, 5'd0));     // Signed -5 below 0x1234
        addInstr(encodeR(F_SLT, 5'd1, 5'd2, 5'd17, 5'd0));
        // Shifts
        addInstr(encodeI(OP_ADDI, 5'd0, 5'd18, 16'h8000));     // Negative source
        addInstr(encodeR(F_SLL, 5'd0, 5'd1, 5'd19, 5'd4));
        addInstr(encodeR(F_SRL, 5'd0, 5'd18, 5'd20, 5'd8));
        addInstr(encodeR(F_SRA, 5'd0, 5'd18, 5'd21, 5'd8));
        addInstr(encodeI(OP_ADDI, 5'd0, 5'd22, 16'd37));       // Low five bits are 5
        addInstr(encodeR(F_SLLV, 5'd22, 5'd1, 5'd23, 5'd0));
        addInstr(encodeR(F_SRLV, 5'd22, 5'd18, 5'd24, 5'd0));
        addInstr(encodeR(F_SRAV, 5'd22, 5'd18, 5'd25, 5'd0));
        addIdle();
        addIdle();
        // Branch and memory address
        addInstr(encodeI(OP_BEQ, 5'd1, 5'd1, 16'h0010));
        addInstr(encodeI(OP_BEQ, 5'd1, 5'd2, 16'h0010));
        addInstr(encodeI(OP_LW, 5'd1, 5'd26, 16'hFFFC));
        addInstr(encodeI(OP_SW, 5'd1, 5'd3, 16'h0010));
        // Unknown codes
        addInstr(encodeR(6'b111111, 5'd1, 5'd2, 5'd27, 5'd0));
        addInstr(encodeR(F_ADD, 5'd27, 5'd1, 5'd28, 5'd0));    // r27 never written
        addInstr(encodeI(6'b111101, 5'd1, 5'd29, 16'h0000));
        // Random R-type mix into r30
        for (k = 0; k < 4; k++)
        begin
            rnd = $urandom();
            case (rnd[2:0])
                3'd0:    pick = F_ADD;
                3'd1:    pick = F_SUB;
                3'd2:    pick = F_AND;
                3'd3:    pick = F_OR;
                3'd4:    pick = F_XOR;
                3'd5:    pick = F_NOR;
                3'd6:    pick = F_SLT;
                default: pick = F_SRAV;
            endcase
            addInstr(encodeR(pick, rnd[12:8], rnd[20:16], 5'd30, 5'd0));
        end
    endtask

    //////////////////////////////
    // Reset and drive loop
    //////////////////////////////
    initial
    begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        rowIdx     = '0;
        expData    = '0;
        expReg     = '0;
        expWrite   = 1'b0;
        expZero    = 1'b0;
        tableReady = 1'b0;
        rnd        = $urandom(32'hb320);
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < rowCount; i++)
        begin
            @(posedge clk);
            instrValid <= tabValid[i];
            instr      <= tabInstr[i];
            rowIdx     <= i;
            expData    <= tabData[i];
            expReg     <= tabReg[i];
            expWrite   <= tabWrite[i];
            expZero    <= tabZero[i];
        end
        @(posedge clk);
        instrValid <= 1'b0;
        wait (checkCount == validRows);
        repeat (3) @(posedge clk);      // Catch stray strobes
        $display("Summary: %0d of %0d results checked, %0d errors",
                 checkCount, validRows, errCount);
        if (errCount == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial
    begin
        wait (tableReady);
        #((rowCount + 10 + 20) * 8);
        $display("Timeout: run did not finish within %0d cycles", rowCount + 30);
        $display("Summary: %0d of %0d results checked, %0d errors",
                 checkCount, validRows, errCount);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
design/mipsPkg.sv
design/ctrlIf.sv
design/mainControl.sv
design/aluControl.sv
design/regFile.sv
design/alu.sv
design/execUnit.sv
dv/tbClock.sv
dv/execChecker.sv
dv/tbExecUnit.sv

// ==== Bender.yml ====
package:
  name: mips_exec

sources:
  - design/mipsPkg.sv
  - design/ctrlIf.sv
  - design/mainControl.sv
  - design/aluControl.sv
  - design/regFile.sv
  - design/alu.sv
  - design/execUnit.sv
  - target: test
    files:
      - dv/tbClock.sv
      - dv/execChecker.sv
      - dv/tbExecUnit.sv
